//--- hw/cache_pkg.sv
// cache package: shared widths, address layout, request and event types for the cache
`default_nettype none

package cache_pkg;

    localparam int ADDR_WIDTH = 16; // word address
    localparam int DATA_WIDTH = 32;
    localparam int SET_WIDTH  = 2;  // four sets
    localparam int TAG_WIDTH  = ADDR_WIDTH - SET_WIDTH;
    localparam int NUM_WAYS   = 2;
    localparam int CNT_WIDTH  = 16; // per event counter

    typedef logic [DATA_WIDTH-1:0] word_t;
    typedef logic [TAG_WIDTH-1:0]  tag_t;

    // one word per line, so the set index sits right at the bottom
    typedef struct packed {
        tag_t                 tag;
        logic [SET_WIDTH-1:0] set;
    } addr_t;

    // request from the cpu side
    typedef struct packed {
        logic  we;    // 1 = write
        addr_t addr;
        word_t wdata;
    } cpu_req_t;

    typedef struct packed {
        word_t rdata; // zero for writes
    } cpu_rsp_t;

    // request towards the backing memory
    typedef struct packed {
        logic  we;
        addr_t addr;
        word_t wdata;
    } mem_req_t;

    // register map
    typedef enum logic [1:0] {
        CTRL   = 2'd0, // bit 0 is bypass
        HITS   = 2'd1,
        MISSES = 2'd2,
        WBACKS = 2'd3
    } csr_addr_e;

    // single-cycle strobes, controller to register block
    typedef struct packed {
        logic hit;
        logic miss;
        logic writeback;
    } cache_evt_t;

endpackage

`default_nettype wire

//--- hw/set_array_ram.sv
// set array RAM: single-port store indexed by set, registered read, payload type set per instance
`timescale 1ns/1ps
`default_nettype none

module set_array_ram #(
    parameter type entry_t     = logic [31:0],
    parameter int  DEPTH_WIDTH = 2
) (
    input  wire logic                   clk_i,
    input  wire logic                   we_i,
    input  wire logic [DEPTH_WIDTH-1:0] idx_i,
    input  wire entry_t                 wdata_i,
    output entry_t                      rdata_o
);

    localparam int DEPTH = 1 << DEPTH_WIDTH;

    // one entry per set, contents come up undefined
    entry_t mem [DEPTH];

    // write port
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem[idx_i] <= wdata_i;
        end
    end

    // read port, one cycle latency
    // a read in the same cycle as a write to that entry
    // returns the old contents
    always_ff @(posedge clk_i) begin
        rdata_o <= mem[idx_i];
    end

endmodule

`default_nettype wire

//--- hw/two_way.sv
// two-way cache controller: lookup, LRU, write allocate, write-back and refill sequencing
`timescale 1ns/1ps
`default_nettype none

module two_way #(
    parameter int SET_WIDTH = 2,
    parameter int TAG_WIDTH = 14
) (
    input  wire logic                 clk_i,
    input  wire logic                 reset_i,
    input  wire logic                 req_valid_i,
    input  wire cache_pkg::cpu_req_t  req_i,
    input  wire logic                 bypass_i,
    output logic                      rsp_valid_o,
    output cache_pkg::cpu_rsp_t       rsp_o,
    output logic                      mem_req_valid_o,
    output cache_pkg::mem_req_t       mem_req_o,
    input  wire logic                 mem_rsp_valid_i,
    input  wire cache_pkg::word_t     mem_rdata_i,
    output cache_pkg::cache_evt_t     evt_o
);

    localparam int NUM_SETS = 1 << SET_WIDTH;
    localparam int NUM_WAYS = cache_pkg::NUM_WAYS;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_WRITEBACK,
        ST_REFILL,
        ST_BYPASS
    } state_e;

    state_e                            state_q;
    cache_pkg::cpu_req_t               req_q; // held through the miss sequence
    logic [SET_WIDTH-1:0]              req_set;
    logic [TAG_WIDTH-1:0]              req_tag;
    logic [NUM_WAYS-1:0][NUM_SETS-1:0] valid_q;
    logic [NUM_WAYS-1:0][NUM_SETS-1:0] dirty_q;
    logic [NUM_SETS-1:0]               lru_q; // way to evict next

    logic [SET_WIDTH-1:0]              ram_idx;
    logic [NUM_WAYS-1:0]               tag_we;
    logic [NUM_WAYS-1:0]               data_we;
    cache_pkg::word_t                  data_wdata;
    cache_pkg::tag_t                   tag_rdata [NUM_WAYS];
    cache_pkg::word_t                  data_rdata [NUM_WAYS];

    logic [NUM_WAYS-1:0]               hit_way;
    logic                              hit;
    logic                              hit_idx;
    logic                              victim;
    logic                              victim_dirty;
    logic                              lookup_hit;
    logic                              lookup_miss;
    logic                              wb_done;
    logic                              refill_done;
    logic                              fill_write;
    logic                              fill;
    cache_pkg::word_t                  rsp_data_d;
    cache_pkg::mem_req_t               refill_req;

    assign req_set = req_q.addr.set;
    assign req_tag = req_q.addr.tag;
    // arrays are read with the incoming set while idle
    assign ram_idx = (state_q == ST_IDLE) ? req_i.addr.set : req_set;

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit_way[w] = valid_q[w][req_set] && (tag_rdata[w] == req_tag);
        end
    end

    assign hit          = |hit_way;
    assign hit_idx      = hit_way[1];
    assign victim       = lru_q[req_set]; // stable until the fill updates LRU
    assign victim_dirty = valid_q[victim][req_set] && dirty_q[victim][req_set];

    assign lookup_hit  = (state_q == ST_LOOKUP) && hit;
    assign lookup_miss = (state_q == ST_LOOKUP) && !hit;
    assign wb_done     = (state_q == ST_WRITEBACK) && mem_rsp_valid_i;
    assign refill_done = (state_q == ST_REFILL) && mem_rsp_valid_i;
    // write miss allocates straight from the request data
    assign fill_write  = req_q.we && ((lookup_miss && !victim_dirty) || wb_done);
    assign fill        = fill_write || refill_done;

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            tag_we[w]  = fill && (victim == 1'(w));
            data_we[w] = tag_we[w] || (lookup_hit && req_q.we && hit_way[w]);
        end
    end

    assign data_wdata = refill_done ? mem_rdata_i : req_q.wdata;
    assign refill_req = '{we: 1'b0, addr: req_q.addr, wdata: '0};

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        set_array_ram #(
            .entry_t    (cache_pkg::tag_t),
            .DEPTH_WIDTH(SET_WIDTH)
        ) u_tag_ram (
            .clk_i  (clk_i),
            .we_i   (tag_we[w]),
            .idx_i  (ram_idx),
            .wdata_i(req_tag),
            .rdata_o(tag_rdata[w])
        );

        set_array_ram #(
            .entry_t    (cache_pkg::word_t),
            .DEPTH_WIDTH(SET_WIDTH)
        ) u_data_ram (
            .clk_i  (clk_i),
            .we_i   (data_we[w]),
            .idx_i  (ram_idx),
            .wdata_i(data_wdata),
            .rdata_o(data_rdata[w])
        );
    end

    always_comb begin
        rsp_data_d = '0; // writes answer with zero
        if (!req_q.we) begin
            rsp_data_d = lookup_hit ? data_rdata[hit_idx] : mem_rdata_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q         <= ST_IDLE;
            valid_q         <= '0;
            dirty_q         <= '0;
            lru_q           <= '0;
            rsp_valid_o     <= 1'b0;
            mem_req_valid_o <= 1'b0;
        end else begin
            rsp_valid_o     <= 1'b0;
            mem_req_valid_o <= 1'b0;
            case (state_q)
                ST_IDLE: begin
                    if (req_valid_i) begin
                        req_q <= req_i;
                        if (bypass_i) begin
                            mem_req_valid_o <= 1'b1;
                            mem_req_o <= '{we: req_i.we, addr: req_i.addr, wdata: req_i.wdata};
                            state_q <= ST_BYPASS;
                        end else begin
                            state_q <= ST_LOOKUP;
                        end
                    end
                end
                ST_LOOKUP: begin
                    if (hit) begin
                        lru_q[req_set] <= !hit_idx;
                        if (req_q.we) begin
                            dirty_q[hit_idx][req_set] <= 1'b1;
                        end
                        state_q <= ST_IDLE;
                    end else if (victim_dirty) begin
                        // victim goes back to memory first
                        mem_req_valid_o <= 1'b1;
                        mem_req_o <= '{we:    1'b1,
                                       addr:  '{tag: tag_rdata[victim], set: req_set},
                                       wdata: data_rdata[victim]};
                        state_q <= ST_WRITEBACK;
                    end else if (req_q.we) begin
                        state_q <= ST_IDLE;
                    end else begin
                        mem_req_valid_o <= 1'b1;
                        mem_req_o       <= refill_req;
                        state_q         <= ST_REFILL;
                    end
                end
                ST_WRITEBACK: begin
                    if (mem_rsp_valid_i) begin
                        if (req_q.we) begin
                            state_q <= ST_IDLE;
                        end else begin
                            mem_req_valid_o <= 1'b1;
                            mem_req_o       <= refill_req;
                            state_q         <= ST_REFILL;
                        end
                    end
                end
                ST_REFILL, ST_BYPASS: begin
                    if (mem_rsp_valid_i) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase

            if (fill) begin
                valid_q[victim][req_set] <= 1'b1;
                dirty_q[victim][req_set] <= req_q.we; // written lines are dirty
                lru_q[req_set]           <= !victim;
            end
            if (lookup_hit || fill || (state_q == ST_BYPASS && mem_rsp_valid_i)) begin
                rsp_valid_o <= 1'b1;
                rsp_o.rdata <= rsp_data_d;
            end
        end
    end

    assign evt_o = '{hit: lookup_hit, miss: lookup_miss, writeback: wb_done};

    // one request in flight, the requester waits for the response
    a_no_req_busy: assert property (@(posedge clk_i) disable iff (reset_i)
        req_valid_i |-> state_q == ST_IDLE);

    a_one_evt: assert property (@(posedge clk_i) disable iff (reset_i)
        $onehot0(evt_o));

    // a line is never allocated twice in one set
    a_unique_tag: assert property (@(posedge clk_i) disable iff (reset_i)
        (state_q == ST_LOOKUP) && valid_q[0][req_set] && valid_q[1][req_set]
        |-> tag_rdata[0] != tag_rdata[1]);

endmodule

`default_nettype wire

//--- hw/data_memory.sv
// backing memory: word array answering every request after a fixed latency
`timescale 1ns/1ps
`default_nettype none

module data_memory #(
    parameter int ADDR_WIDTH  = 16,
    parameter int MEM_LATENCY = 2
) (
    input  wire logic                clk_i,
    input  wire logic                reset_i,
    input  wire logic                req_valid_i,
    input  wire cache_pkg::mem_req_t req_i,
    output logic                     rsp_valid_o,
    output cache_pkg::word_t         rdata_o
);

    localparam int DEPTH = 1 << ADDR_WIDTH;

    cache_pkg::word_t       mem [DEPTH];
    logic [ADDR_WIDTH-1:0]  word_addr;
    logic [MEM_LATENCY-1:0] valid_sr; // response strobe pipeline
    cache_pkg::word_t       data_sr [MEM_LATENCY];

    assign word_addr = req_i.addr;

    always_ff @(posedge clk_i) begin
        if (req_valid_i && req_i.we) begin
            mem[word_addr] <= req_i.wdata;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_sr <= '0;
        end else begin
            valid_sr[0] <= req_valid_i; // writes are answered too
            for (int i = 1; i < MEM_LATENCY; i++) begin
                valid_sr[i] <= valid_sr[i-1];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        data_sr[0] <= req_i.we ? '0 : mem[word_addr];
        for (int i = 1; i < MEM_LATENCY; i++) begin
            data_sr[i] <= data_sr[i-1];
        end
    end

    assign rsp_valid_o = valid_sr[MEM_LATENCY-1];
    assign rdata_o     = data_sr[MEM_LATENCY-1];

    // the controller waits for each answer before the next request
    a_one_in_flight: assert property (@(posedge clk_i) disable iff (reset_i)
        req_valid_i |-> !(|valid_sr));

endmodule

`default_nettype wire

//--- hw/cache_csr.sv
// cache register block: bypass control and saturating hit, miss and write-back counters
`timescale 1ns/1ps
`default_nettype none

module cache_csr #(
    parameter int CNT_WIDTH = 16
) (
    input  wire logic                  clk_i,
    input  wire logic                  reset_i,
    input  wire logic                  we_i,
    input  wire cache_pkg::csr_addr_e  addr_i,
    input  wire cache_pkg::word_t      wdata_i,
    output cache_pkg::word_t           rdata_o,
    input  wire cache_pkg::cache_evt_t evt_i,
    output logic                       bypass_o
);

    logic                 bypass_q;
    logic [CNT_WIDTH-1:0] hits_q;
    logic [CNT_WIDTH-1:0] misses_q;
    logic [CNT_WIDTH-1:0] wbacks_q;

    // holds at all ones
    function automatic logic [CNT_WIDTH-1:0] sat_inc(input logic [CNT_WIDTH-1:0] cnt,
                                                     input logic ev);
        sat_inc = (ev && cnt != '1) ? cnt + 1'b1 : cnt;
    endfunction

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            bypass_q <= 1'b0;
            hits_q   <= '0;
            misses_q <= '0;
            wbacks_q <= '0;
        end else if (we_i && addr_i == cache_pkg::CTRL) begin
            bypass_q <= wdata_i[0];
        end else if (we_i) begin
            // any counter write clears all three
            hits_q   <= '0;
            misses_q <= '0;
            wbacks_q <= '0;
        end else begin
            hits_q   <= sat_inc(hits_q, evt_i.hit);
            misses_q <= sat_inc(misses_q, evt_i.miss);
            wbacks_q <= sat_inc(wbacks_q, evt_i.writeback);
        end
    end

    always_comb begin
        rdata_o = '0;
        case (addr_i)
            cache_pkg::CTRL:   rdata_o[0]           = bypass_q;
            cache_pkg::HITS:   rdata_o[CNT_WIDTH-1:0] = hits_q;
            cache_pkg::MISSES: rdata_o[CNT_WIDTH-1:0] = misses_q;
            default:           rdata_o[CNT_WIDTH-1:0] = wbacks_q;
        endcase
    end

    assign bypass_o = bypass_q;

endmodule

`default_nettype wire

//--- hw/cache_top.sv
// cache top: controller, register block and backing memory wired together
`timescale 1ns/1ps
`default_nettype none

module cache_top #(
    parameter int ADDR_WIDTH  = cache_pkg::ADDR_WIDTH,
    parameter int SET_WIDTH   = cache_pkg::SET_WIDTH,
    parameter int TAG_WIDTH   = cache_pkg::TAG_WIDTH,
    parameter int CNT_WIDTH   = cache_pkg::CNT_WIDTH,
    parameter int MEM_LATENCY = 2
) (
    input  wire logic                 clk_i,
    input  wire logic                 reset_i,
    input  wire logic                 cpu_req_valid_i,
    input  wire cache_pkg::cpu_req_t  cpu_req_i,
    output logic                      cpu_rsp_valid_o,
    output cache_pkg::cpu_rsp_t       cpu_rsp_o,
    input  wire logic                 csr_we_i,
    input  wire cache_pkg::csr_addr_e csr_addr_i,
    input  wire cache_pkg::word_t     csr_wdata_i,
    output cache_pkg::word_t          csr_rdata_o
);

    logic                  mem_req_valid;
    cache_pkg::mem_req_t   mem_req;
    logic                  mem_rsp_valid;
    cache_pkg::word_t      mem_rdata;
    cache_pkg::cache_evt_t evt;
    logic                  bypass; // sampled by the controller on accept

    two_way #(
        .SET_WIDTH(SET_WIDTH),
        .TAG_WIDTH(TAG_WIDTH)
    ) u_two_way (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .req_valid_i    (cpu_req_valid_i),
        .req_i          (cpu_req_i),
        .bypass_i       (bypass),
        .rsp_valid_o    (cpu_rsp_valid_o),
        .rsp_o          (cpu_rsp_o),
        .mem_req_valid_o(mem_req_valid),
        .mem_req_o      (mem_req),
        .mem_rsp_valid_i(mem_rsp_valid),
        .mem_rdata_i    (mem_rdata),
        .evt_o          (evt)
    );

    data_memory #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .MEM_LATENCY(MEM_LATENCY)
    ) u_data_memory (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .req_valid_i(mem_req_valid),
        .req_i      (mem_req),
        .rsp_valid_o(mem_rsp_valid),
        .rdata_o    (mem_rdata)
    );

    cache_csr #(
        .CNT_WIDTH(CNT_WIDTH)
    ) u_cache_csr (
        .clk_i   (clk_i),
        .reset_i (reset_i),
        .we_i    (csr_we_i),
        .addr_i  (csr_addr_i),
        .wdata_i (csr_wdata_i),
        .rdata_o (csr_rdata_o),
        .evt_i   (evt),
        .bypass_o(bypass)
    );

endmodule

`default_nettype wire

//--- verif/cache_tb.sv
// cache testbench: reference cache model, directed and random requests, response and counter checks
`timescale 1ns/1ps
`default_nettype none

module cache_tb;

    localparam int TIMEOUT = 50; // cycles allowed for any one wait

    logic                 clk_i = 1'b0;
    logic                 reset_i = 1'b1;
    logic                 cpu_req_valid_i = 1'b0;
    cache_pkg::cpu_req_t  cpu_req_i = '0;
    logic                 cpu_rsp_valid_o;
    cache_pkg::cpu_rsp_t  cpu_rsp_o;
    logic                 csr_we_i = 1'b0;
    cache_pkg::csr_addr_e csr_addr_i = cache_pkg::CTRL;
    cache_pkg::word_t     csr_wdata_i = '0;
    cache_pkg::word_t     csr_rdata_o;

    // reference model state
    cache_pkg::word_t ref_mem [1 << cache_pkg::ADDR_WIDTH];
    cache_pkg::tag_t  ref_tag [2][4];
    cache_pkg::word_t ref_data [2][4];
    bit               ref_valid [2][4];
    bit               ref_dirty [2][4];
    bit               ref_lru [4]; // way evicted next
    int               ref_hits;
    int               ref_misses;
    int               ref_wbacks;
    bit               bypass_on;

    cache_pkg::word_t exp_q [$]; // expected read data, oldest first
    cache_pkg::word_t snap [4];  // model counters at the start of a step, by register index
    int               err_count;
    int               check_count;
    int               test_count;
    int               test_err_start;

    always #20 clk_i = ~clk_i;

    cache_top i_dut (.*);

    // applies one request to the model and returns the expected read data
    function automatic cache_pkg::word_t ref_access(input bit we, input logic [15:0] addr,
                                                    input cache_pkg::word_t wdata);
        logic [1:0]       set;
        cache_pkg::tag_t  tag;
        int               way;
        set = addr[1:0];
        tag = addr[15:2];
        way = -1;
        if (bypass_on) begin
            // memory only, cached copies may go stale
            if (we) begin
                ref_mem[addr] = wdata;
            end
            return we ? 32'h0 : ref_mem[addr];
        end
        for (int w = 0; w < 2; w++) begin
            if (ref_valid[w][set] && ref_tag[w][set] == tag) begin
                way = w;
            end
        end
        if (way >= 0) begin
            ref_hits++;
            if (we) begin
                ref_data[way][set] = wdata;
                ref_dirty[way][set] = 1'b1;
            end
        end else begin
            ref_misses++;
            way = int'(ref_lru[set]);
            if (ref_valid[way][set] && ref_dirty[way][set]) begin
                ref_mem[{ref_tag[way][set], set}] = ref_data[way][set]; // write-back
                ref_wbacks++;
            end
            ref_tag[way][set] = tag;
            ref_valid[way][set] = 1'b1;
            ref_dirty[way][set] = we;
            ref_data[way][set] = we ? wdata : ref_mem[addr];
        end
        ref_lru[set] = (way == 0); // point at the other way
        return we ? 32'h0 : ref_data[way][set];
    endfunction

    function automatic bit is_cached(input logic [15:0] addr);
        bit found;
        found = 1'b0;
        for (int w = 0; w < 2; w++) begin
            found |= ref_valid[w][addr[1:0]] && (ref_tag[w][addr[1:0]] == addr[15:2]);
        end
        return found;
    endfunction

    // depends on every address bit
    function automatic cache_pkg::word_t fill_value(input logic [15:0] addr);
        return {addr ^ 16'h5a5a, ~addr};
    endfunction

    task automatic check_value(input string name, input cache_pkg::word_t actual,
                               input cache_pkg::word_t expected);
        check_count++;
        if (actual !== expected) begin
            err_count++;
            $display("FAILED at %0t: %s = 0x%h, expected 0x%h", $time, name, actual, expected);
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout at %0t: %s within %0d cycles", $time, what, TIMEOUT);
        $display("TEST FAILED");
        $finish;
    endtask

    task automatic csr_write(input cache_pkg::csr_addr_e addr, input cache_pkg::word_t data);
        @(posedge clk_i);
        #2;
        csr_we_i    = 1'b1;
        csr_addr_i  = addr;
        csr_wdata_i = data;
        @(posedge clk_i);
        #2;
        csr_we_i = 1'b0;
    endtask

    task automatic csr_read(input cache_pkg::csr_addr_e addr, output cache_pkg::word_t data);
        @(posedge clk_i);
        #2;
        csr_addr_i = addr;
        @(negedge clk_i);
        data = csr_rdata_o; // combinational read
    endtask

    task automatic set_bypass(input bit on);
        cache_pkg::word_t value;
        csr_write(cache_pkg::CTRL, {31'b0, on});
        bypass_on = on;
        csr_read(cache_pkg::CTRL, value);
        check_value("CTRL", value, {31'b0, on});
    endtask

    // one request, then wait until the compare process has seen its response
    task automatic cpu_access(input bit we, input logic [15:0] addr,
                              input cache_pkg::word_t wdata);
        int cycles;
        exp_q.push_back(ref_access(we, addr, wdata));
        @(posedge clk_i);
        #2;
        cpu_req_valid_i = 1'b1;
        cpu_req_i       = {we, addr, wdata};
        @(posedge clk_i);
        #2;
        cpu_req_valid_i = 1'b0;
        cycles = 0;
        while (exp_q.size() != 0 && cycles <= TIMEOUT + 5) begin
            @(posedge clk_i);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            stop_on_timeout("request never completed");
        end
    endtask

    task automatic check_counters();
        cache_pkg::word_t value;
        csr_read(cache_pkg::HITS, value);
        check_value("HITS", value, 32'(ref_hits));
        csr_read(cache_pkg::MISSES, value);
        check_value("MISSES", value, 32'(ref_misses));
        csr_read(cache_pkg::WBACKS, value);
        check_value("WBACKS", value, 32'(ref_wbacks));
    endtask

    task automatic take_snapshot();
        snap[1] = 32'(ref_hits);
        snap[2] = 32'(ref_misses);
        snap[3] = 32'(ref_wbacks);
    endtask

    task automatic check_step(input cache_pkg::csr_addr_e addr, input int step);
        cache_pkg::word_t value;
        csr_read(addr, value);
        check_value(addr.name(), value, snap[addr] + 32'(step));
    endtask

    task automatic finish_test(input string name);
        test_count++;
        $display("test %0d, %s: %s", test_count, name,
                 (err_count == test_err_start) ? "pass" : "fail");
        test_err_start = err_count;
    endtask

    // every response strobe is matched against the oldest expected value
    initial begin : compare
        int wait_cycles;
        wait_cycles = 0;
        forever begin
            @(negedge clk_i);
            if (cpu_rsp_valid_o) begin
                if (exp_q.size() == 0) begin
                    err_count++;
                    $display("response strobe at %0t with no request pending", $time);
                end else begin
                    check_value("cpu_rsp_o.rdata", cpu_rsp_o.rdata, exp_q.pop_front());
                end
                wait_cycles = 0;
            end else if (exp_q.size() != 0) begin
                wait_cycles++;
                if (wait_cycles > TIMEOUT) begin
                    stop_on_timeout("no response strobe from the cache");
                end
            end
        end
    end

    initial begin : stimulus
        void'($urandom(32'hb77d));
        repeat (8) @(posedge clk_i);
        #2;
        reset_i = 1'b0;

        set_bypass(1'b1);
        for (int a = 0; a < 64; a++) begin
            cpu_access(1'b1, 16'(a), fill_value(16'(a)));
        end
        for (int a = 0; a < 64; a++) begin
            cpu_access(1'b0, 16'(a), '0);
        end
        check_counters(); // still all zero
        finish_test("bypass fill and readback");

        set_bypass(1'b0);
        take_snapshot();
        cpu_access(1'b0, 16'd4, '0);
        cpu_access(1'b0, 16'd4, '0);
        check_step(cache_pkg::HITS, 1);
        check_step(cache_pkg::MISSES, 1);
        finish_test("read miss then hit");

        // 1, 5 and 9 all land in set 1
        take_snapshot();
        cpu_access(1'b0, 16'd1, '0);
        cpu_access(1'b0, 16'd5, '0);
        cpu_access(1'b0, 16'd9, '0);
        if (is_cached(16'd5)) begin
            cpu_access(1'b0, 16'd5, '0);
            cpu_access(1'b0, 16'd1, '0);
        end else begin
            cpu_access(1'b0, 16'd1, '0);
            cpu_access(1'b0, 16'd5, '0);
        end
        check_step(cache_pkg::HITS, 1);
        check_step(cache_pkg::MISSES, 4);
        check_counters();
        finish_test("two ways and LRU eviction");

        take_snapshot();
        cpu_access(1'b1, 16'd2, 32'hdead_0002); // allocates dirty in set 2
        set_bypass(1'b1);
        cpu_access(1'b0, 16'd2, '0);            // memory still holds the old value
        set_bypass(1'b0);
        cpu_access(1'b0, 16'd6, '0);
        cpu_access(1'b0, 16'd10, '0);           // evicts address 2
        check_step(cache_pkg::WBACKS, 1);
        set_bypass(1'b1);
        cpu_access(1'b0, 16'd2, '0);
        set_bypass(1'b0);
        check_counters();
        finish_test("dirty write-back");

        for (int i = 0; i < 300; i++) begin
            cpu_access(1'($urandom), 16'($urandom % 32), $urandom);
        end
        check_counters();
        finish_test("random mix");

        csr_write(cache_pkg::HITS, '0);
        ref_hits   = 0;
        ref_misses = 0;
        ref_wbacks = 0;
        check_counters();
        cpu_access(1'b0, 16'd20, '0);
        cpu_access(1'b0, 16'd20, '0);
        check_counters();
        finish_test("counter clear");

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
hw/cache_pkg.sv
hw/set_array_ram.sv
hw/two_way.sv
hw/data_memory.sv
hw/cache_csr.sv
hw/cache_top.sv
verif/cache_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the cache testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module cache_tb -Mdir obj_dir

out=$(./obj_dir/Vcache_tb)
echo "$out"

if echo "$out" | grep -q "^TEST OK$"; then
    exit 0
fi
exit 1
